// File: build.f
+incdir+design
design/csr_pkg.sv
design/irq_arbiter.sv
design/trap_ctrl.sv
design/csr_file.sv
design/csr_unit.sv
sim/csr_unit_sva.sv
sim/csr_unit_tb.sv

// File: design/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Data word width of the hart
`define CSR_XLEN 32

// mtime and mtimecmp width
`define CSR_TIME_W 64

// MXL=1 (RV32), extension bits I and M
`define CSR_MISA_VALUE 32'h4000_1100

// mtvec mode field, bits 1:0
`define CSR_TVEC_DIRECT 2'd0
`define CSR_TVEC_VECTORED 2'd1

`endif

// File: design/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module csr_file (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       csr_valid,
    input  wire csr_pkg::csr_cmd_e    csr_cmd,
    input  wire [11:0]                csr_addr,
    input  wire [`CSR_XLEN-1:0]       op1_data,
    input  wire [`CSR_XLEN-1:0]       pc,
    input  wire [`CSR_TIME_W-1:0]     mtime,
    input  wire [2:0]                 mip_bits,     // [2] ext, [1] timer, [0] sw
    input  wire                       enter_trap,
    input  wire                       do_mret,
    input  wire [`CSR_XLEN-1:0]       trap_cause,
    output logic [`CSR_XLEN-1:0]      rdata,
    output logic [`CSR_XLEN-1:0]      mtvec,
    output logic [`CSR_XLEN-1:0]      mepc,
    output logic [2:0]                mie_bits,
    output logic                      mstatus_mie,
    output csr_pkg::priv_mode_e       priv_mode
);

    import csr_pkg::*;

    priv_mode_e           mpp;
    logic                 mpie;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mcause;

    csr_word_u            mstatus_w;    // Read views
    csr_word_u            mie_w;
    csr_word_u            mip_w;
    csr_word_u            wr_word;      // Value a W/S/C would write

    logic [`CSR_XLEN-1:0] rd_raw;
    logic                 can_access;
    logic                 can_write;
    logic                 is_rw_cmd;
    logic                 do_write;

    // Address bits 9:8 give the lowest mode allowed, 11:10 == 11 is read-only
    assign can_access = (csr_addr[9:8] <= priv_mode);
    assign can_write  = can_access && (csr_addr[11:10] != 2'b11);

    always_comb begin
        mstatus_w.raw     = '0;
        mstatus_w.st.mpp  = mpp;
        mstatus_w.st.mpie = mpie;
        mstatus_w.st.mie  = mstatus_mie;
        mie_w.raw         = '0;
        mie_w.irq.ext     = mie_bits[2];
        mie_w.irq.tmr     = mie_bits[1];
        mie_w.irq.sw      = mie_bits[0];
        mip_w.raw         = '0;
        mip_w.irq.ext     = mip_bits[2];
        mip_w.irq.tmr     = mip_bits[1];
        mip_w.irq.sw      = mip_bits[0];
    end

    always_comb begin
        case (csr_addr)
            ADDR_MSTATUS:  rd_raw = mstatus_w.raw;
            ADDR_MISA:     rd_raw = `CSR_MISA_VALUE;
            ADDR_MIE:      rd_raw = mie_w.raw;
            ADDR_MTVEC:    rd_raw = mtvec;
            ADDR_MSCRATCH: rd_raw = mscratch;
            ADDR_MEPC:     rd_raw = mepc;
            ADDR_MCAUSE:   rd_raw = mcause;
            ADDR_MIP:      rd_raw = mip_w.raw;
            ADDR_TIME:     rd_raw = mtime[`CSR_XLEN-1:0];
            ADDR_TIMEH:    rd_raw = mtime[`CSR_TIME_W-1:`CSR_XLEN];
            default:       rd_raw = '0;      // Unknown CSRs read zero
        endcase
    end

    assign rdata = can_access ? rd_raw : '0;

    // Set and clear work on the visible (checked) read value
    always_comb begin
        case (csr_cmd)
            CMD_W:   wr_word.raw = op1_data;
            CMD_S:   wr_word.raw = rdata | op1_data;
            CMD_C:   wr_word.raw = rdata & ~op1_data;
            default: wr_word.raw = rdata;
        endcase
    end

    assign is_rw_cmd = (csr_cmd == CMD_W) || (csr_cmd == CMD_S) || (csr_cmd == CMD_C);
    assign do_write  = csr_valid && is_rw_cmd && can_write && !enter_trap;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv_mode   <= M_MODE;
            mpp         <= U_MODE;
            mpie        <= 1'b0;
            mstatus_mie <= 1'b0;
            mie_bits    <= 3'b000;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
        end else if (enter_trap) begin
            mepc        <= pc;
            mcause      <= trap_cause;
            mpie        <= mstatus_mie;   // Stack the enable
            mstatus_mie <= 1'b0;
            mpp         <= priv_mode;
            priv_mode   <= M_MODE;
        end else if (do_mret) begin
            mstatus_mie <= mpie;
            priv_mode   <= mpp;
            mpie        <= 1'b1;
            mpp         <= U_MODE;        // Least privileged mode
        end else if (do_write) begin
            case (csr_addr)
                ADDR_MSTATUS: begin
                    // Only M and U are legal in mpp
                    mpp         <= (wr_word.st.mpp == M_MODE) ? M_MODE : U_MODE;
                    mpie        <= wr_word.st.mpie;
                    mstatus_mie <= wr_word.st.mie;
                end
                ADDR_MIE: begin
                    mie_bits <= {wr_word.irq.ext, wr_word.irq.tmr, wr_word.irq.sw};
                end
                ADDR_MTVEC:    mtvec    <= wr_word.raw;
                ADDR_MSCRATCH: mscratch <= wr_word.raw;
                ADDR_MEPC:     mepc     <= {wr_word.raw[`CSR_XLEN-1:2], 2'b00};
                ADDR_MCAUSE:   mcause   <= wr_word.raw;
                default: begin
                    // misa, mip and time are not writable
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/csr_pkg.sv
`default_nettype none

package csr_pkg;

`include "csr_cfg.svh"

    // Only M and U exist on this hart
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        M_MODE = 2'd3
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,     // CSRRW
        CMD_S     = 3'd2,     // CSRRS
        CMD_C     = 3'd3,     // CSRRC
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    typedef enum logic [11:0] {
        ADDR_MSTATUS  = 12'h300,
        ADDR_MISA     = 12'h301,  // Read as constant
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MIP      = 12'h344,  // Hardware levels only
        ADDR_TIME     = 12'hc01,
        ADDR_TIMEH    = 12'hc81
    } csr_addr_e;

    // Top bit of mcause marks an interrupt
    localparam logic [`CSR_XLEN-1:0] IRQ_BIT = {1'b1, {(`CSR_XLEN-1){1'b0}}};

    localparam logic [`CSR_XLEN-1:0] CAUSE_MSI     = IRQ_BIT | `CSR_XLEN'(3);
    localparam logic [`CSR_XLEN-1:0] CAUSE_MTI     = IRQ_BIT | `CSR_XLEN'(7);
    localparam logic [`CSR_XLEN-1:0] CAUSE_MEI     = IRQ_BIT | `CSR_XLEN'(11);
    localparam logic [`CSR_XLEN-1:0] CAUSE_ECALL_U = `CSR_XLEN'(8);
    localparam logic [`CSR_XLEN-1:0] CAUSE_ECALL_M = `CSR_XLEN'(11);

    // mstatus fields kept by this hart
    typedef struct packed {
        logic [`CSR_XLEN-14:0] rsvd_hi;
        logic [1:0]            mpp;      // Bits 12:11
        logic [2:0]            rsvd_mid;
        logic                  mpie;     // Bit 7
        logic [2:0]            rsvd_lo;
        logic                  mie;      // Bit 3
        logic [2:0]            rsvd_0;
    } mstatus_view_t;

    // Same layout serves mie and mip
    typedef struct packed {
        logic [`CSR_XLEN-13:0] rsvd_hi;
        logic                  ext;      // Bit 11, MEI
        logic [2:0]            rsvd_mid;
        logic                  tmr;      // Bit 7, MTI
        logic [2:0]            rsvd_lo;
        logic                  sw;       // Bit 3, MSI
        logic [2:0]            rsvd_0;
    } irq_view_t;

    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        mstatus_view_t        st;
        irq_view_t            irq;
    } csr_word_u;

endpackage

`default_nettype wire

// File: design/csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module csr_unit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      csr_valid,
    input  wire csr_pkg::csr_cmd_e   csr_cmd,
    input  wire [11:0]               csr_addr,
    input  wire [`CSR_XLEN-1:0]      op1_data,
    input  wire [`CSR_XLEN-1:0]      pc,
    input  wire [`CSR_TIME_W-1:0]    mtime,
    input  wire [`CSR_TIME_W-1:0]    mtimecmp,
    input  wire                      meip,
    input  wire                      msip,
    output logic [`CSR_XLEN-1:0]     rdata,
    output logic                     trap_flg,
    output logic [`CSR_XLEN-1:0]     trap_vector,
    output csr_pkg::priv_mode_e      priv_mode
);

    logic [2:0]           mip_bits;      // Pending levels, arbiter to CSR file
    logic [2:0]           mie_bits;      // Enables, CSR file to arbiter
    logic                 mstatus_mie;
    logic                 irq_take;
    logic [`CSR_XLEN-1:0] irq_cause;
    logic                 enter_trap;
    logic                 do_mret;
    logic [`CSR_XLEN-1:0] trap_cause;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;

    irq_arbiter u_irq_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .meip        (meip),
        .msip        (msip),
        .mie_bits    (mie_bits),
        .mstatus_mie (mstatus_mie),
        .priv_mode   (priv_mode),
        .mip_bits    (mip_bits),
        .irq_take    (irq_take),
        .irq_cause   (irq_cause)
    );

    trap_ctrl u_trap_ctrl (
        .csr_valid   (csr_valid),
        .csr_cmd     (csr_cmd),
        .priv_mode   (priv_mode),
        .irq_take    (irq_take),
        .irq_cause   (irq_cause),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .enter_trap  (enter_trap),
        .do_mret     (do_mret),
        .trap_cause  (trap_cause),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector)
    );

    // State holder, also the mode source for the other two blocks
    csr_file u_csr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .csr_cmd     (csr_cmd),
        .csr_addr    (csr_addr),
        .op1_data    (op1_data),
        .pc          (pc),
        .mtime       (mtime),
        .mip_bits    (mip_bits),
        .enter_trap  (enter_trap),
        .do_mret     (do_mret),
        .trap_cause  (trap_cause),
        .rdata       (rdata),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mie_bits    (mie_bits),
        .mstatus_mie (mstatus_mie),
        .priv_mode   (priv_mode)
    );

endmodule

`default_nettype wire

// File: design/irq_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

// Bit order of mip_bits and mie_bits: [2] external, [1] timer, [0] software
module irq_arbiter (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [`CSR_TIME_W-1:0]    mtime,
    input  wire [`CSR_TIME_W-1:0]    mtimecmp,
    input  wire                      meip,
    input  wire                      msip,
    input  wire [2:0]                mie_bits,
    input  wire                      mstatus_mie,
    input  wire csr_pkg::priv_mode_e priv_mode,
    output logic [2:0]               mip_bits,
    output logic                     irq_take,
    output logic [`CSR_XLEN-1:0]     irq_cause
);

    import csr_pkg::*;

    logic       mtip;         // Registered compare, one cycle behind mtime
    logic [2:0] irq_live;     // Pending and individually enabled
    logic       global_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

    assign mip_bits  = {meip, mtip, msip};
    assign irq_live  = mip_bits & mie_bits;
    // Lower mode can always be interrupted into M
    assign global_en = (priv_mode == M_MODE) ? mstatus_mie : 1'b1;
    assign irq_take  = global_en && (irq_live != 3'b000);

    // Fixed order MEI > MSI > MTI
    always_comb begin
        if (irq_live[2]) begin
            irq_cause = CAUSE_MEI;
        end else if (irq_live[0]) begin
            irq_cause = CAUSE_MSI;
        end else if (irq_live[1]) begin
            irq_cause = CAUSE_MTI;
        end else begin
            irq_cause = '0;       // Unused when irq_take is low
        end
    end

endmodule

`default_nettype wire

// File: design/trap_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module trap_ctrl (
    input  wire                      csr_valid,
    input  wire csr_pkg::csr_cmd_e   csr_cmd,
    input  wire csr_pkg::priv_mode_e priv_mode,
    input  wire                      irq_take,
    input  wire [`CSR_XLEN-1:0]      irq_cause,
    input  wire [`CSR_XLEN-1:0]      mtvec,
    input  wire [`CSR_XLEN-1:0]      mepc,
    output logic                     enter_trap,
    output logic                     do_mret,
    output logic [`CSR_XLEN-1:0]     trap_cause,
    output logic                     trap_flg,
    output logic [`CSR_XLEN-1:0]     trap_vector
);

    import csr_pkg::*;

    logic                 is_ecall;
    logic [`CSR_XLEN-1:0] ecall_cause;
    logic [`CSR_XLEN-1:0] tvec_base;      // mtvec with mode bits cleared
    logic [`CSR_XLEN-1:0] vec_offset;     // 4 * cause code
    logic [`CSR_XLEN-1:0] trap_target;

    assign is_ecall = (csr_cmd == CMD_ECALL);

    // ECALL takes precedence, an interrupt waits for the next valid cycle
    assign enter_trap = csr_valid && (is_ecall || irq_take);
    assign do_mret    = csr_valid && (csr_cmd == CMD_MRET) && !enter_trap;

    assign ecall_cause = (priv_mode == M_MODE) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
    assign trap_cause  = is_ecall ? ecall_cause : irq_cause;

    assign tvec_base  = {mtvec[`CSR_XLEN-1:2], 2'b00};
    assign vec_offset = {trap_cause[`CSR_XLEN-3:0], 2'b00};  // Drops interrupt bit

    always_comb begin
        case (mtvec[1:0])
            `CSR_TVEC_DIRECT: begin
                trap_target = mtvec;
            end
            `CSR_TVEC_VECTORED: begin
                // Exceptions still land on the base
                if (is_ecall) begin
                    trap_target = tvec_base;
                end else begin
                    trap_target = tvec_base + vec_offset;
                end
            end
            default: begin
                trap_target = mtvec;   // Reserved modes act as direct
            end
        endcase
    end

    assign trap_flg    = enter_trap || do_mret;
    assign trap_vector = enter_trap ? trap_target : mepc;  // MRET returns to mepc

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module csr_unit_tb \
    -f build.f -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/csr_unit_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: sim/csr_tests.dat
# valid cmd addr op1 pc meip msip mtime mtimecmp, then expected rdata trap_flg trap_vector mode
# cmd 0 none 1 csrrw 2 csrrs 3 csrrc 4 ecall 5 mret, trap_vector checked when trap_flg is 1
1 1 340 a5a50000 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 3
1 2 340 000000ff 00000000 0 0 0000000000000100 ffffffffffffffff a5a50000 0 00000000 3
1 3 340 a500000f 00000000 0 0 0000000000000100 ffffffffffffffff a5a500ff 0 00000000 3
1 1 340 12345678 00000000 0 0 0000000000000100 ffffffffffffffff 00a500f0 0 00000000 3
1 1 341 00002003 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 3
1 2 341 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00002000 0 00000000 3
1 1 301 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 40001100 0 00000000 3
1 2 301 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 40001100 0 00000000 3
1 1 305 00001000 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 3
# ECALL from M, then drop to U through MRET
1 4 000 00000000 00000100 0 0 0000000000000100 ffffffffffffffff 00000000 1 00001000 3
1 2 342 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 0000000b 0 00000000 3
1 2 341 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000100 0 00000000 3
1 1 300 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00001800 0 00000000 3
1 5 000 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 1 00000100 0
# U mode access checks and ECALL from U
1 2 340 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 0
1 1 340 ffffffff 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 0
1 2 c01 00000000 00000000 0 0 0000000123456789 ffffffffffffffff 23456789 0 00000000 0
1 2 c81 00000000 00000000 0 0 0000000123456789 ffffffffffffffff 00000001 0 00000000 0
1 4 000 00000000 00000200 0 0 0000000000000100 ffffffffffffffff 00000000 1 00001000 3
1 2 342 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000008 0 00000000 3
1 2 341 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000200 0 00000000 3
1 2 340 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 12345678 0 00000000 3
# MRET with mpp M and mpie 1
1 1 300 00001880 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 3
1 5 000 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 1 00000200 3
1 2 300 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000088 0 00000000 3
# Interrupts, direct mtvec
1 1 304 00000888 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 3
1 0 000 00000000 00000300 1 1 0000000000000100 ffffffffffffffff 00000000 1 00001000 3
1 2 342 00000000 00000000 1 1 0000000000000100 ffffffffffffffff 8000000b 0 00000000 3
1 1 300 00000008 00000000 0 0 0000000000000100 ffffffffffffffff 00001880 0 00000000 3
1 0 000 00000000 00000000 0 0 0000000000000500 0000000000000500 00000000 0 00000000 3
1 0 000 00000000 00000400 0 1 0000000000000500 0000000000000500 00000000 1 00001000 3
1 2 342 00000000 00000000 0 0 0000000000000500 0000000000000500 80000003 0 00000000 3
# Vectored mtvec, MTI taken in U with mstatus.mie clear
1 1 305 00002001 00000000 0 0 0000000000000500 0000000000000500 00001000 0 00000000 3
1 1 300 00000000 00000000 0 0 0000000000000500 0000000000000500 00001880 0 00000000 3
1 5 000 00000000 00000000 0 0 0000000000000500 0000000000000500 00000000 1 00000400 0
1 0 000 00000000 00000500 0 0 0000000000000500 0000000000000500 00000000 1 0000201c 3
1 2 342 00000000 00000000 0 0 0000000000000500 0000000000000500 80000007 0 00000000 3
1 4 000 00000000 00000600 0 0 0000000000000100 ffffffffffffffff 00000000 1 00002000 3
1 1 300 00000008 00000000 0 0 0000000000000100 ffffffffffffffff 00001800 0 00000000 3
1 0 000 00000000 00000700 1 0 0000000000000100 ffffffffffffffff 00000000 1 0000202c 3
1 2 342 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 8000000b 0 00000000 3
1 2 344 00000000 00000000 1 1 0000000000000100 ffffffffffffffff 00000808 0 00000000 3
0 0 000 00000000 00000000 0 0 0000000000000100 ffffffffffffffff 00000000 0 00000000 3

// File: sim/csr_unit_sva.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_sva (
    input wire                      clk,
    input wire                      rst_n,
    input wire                      csr_valid,
    input wire                      trap_flg,
    input wire                      enter_trap,
    input wire csr_pkg::priv_mode_e priv_mode
);

    import csr_pkg::*;

    // Trap or return only on an instruction cycle
    flg_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        trap_flg |-> csr_valid)
        else $error("trap_flg high without csr_valid");

    // Hart comes out of reset in M mode
    mode_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (priv_mode == M_MODE))
        else $error("priv_mode not M after reset");

    trap_enters_m: assert property (@(posedge clk) disable iff (!rst_n)
        enter_trap |=> (priv_mode == M_MODE))
        else $error("priv_mode not M after trap entry");

endmodule

bind csr_unit csr_unit_sva u_csr_unit_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_valid  (csr_valid),
    .trap_flg   (trap_flg),
    .enter_trap (enter_trap),    // Internal, set only for a real trap entry
    .priv_mode  (priv_mode)
);

`default_nettype wire

// File: sim/csr_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module csr_unit_tb;

    import csr_pkg::*;

    localparam string VEC_FILE  = "sim/csr_tests.dat";
    localparam int    MAX_LINES = 200;      // Line-count limit on the file read

    // One line of the vector file
    typedef struct packed {
        logic                   valid;
        logic [2:0]             cmd;
        logic [11:0]            addr;
        logic [`CSR_XLEN-1:0]   op1;
        logic [`CSR_XLEN-1:0]   pc;
        logic                   meip;
        logic                   msip;
        logic [`CSR_TIME_W-1:0] mtime;
        logic [`CSR_TIME_W-1:0] mtimecmp;
        logic [`CSR_XLEN-1:0]   rdata;      // Expected, same cycle
        logic                   trap;       // Expected trap_flg
        logic [`CSR_XLEN-1:0]   vec;        // Expected trap_vector
        logic [1:0]             mode;       // Expected mode after the edge
    } vector_t;

    logic                   clk;
    logic                   rst_n;
    logic                   csr_valid;
    csr_cmd_e               csr_cmd;
    logic [11:0]            csr_addr;
    logic [`CSR_XLEN-1:0]   op1_data;
    logic [`CSR_XLEN-1:0]   pc;
    logic [`CSR_TIME_W-1:0] mtime;
    logic [`CSR_TIME_W-1:0] mtimecmp;
    logic                   meip;
    logic                   msip;
    logic [`CSR_XLEN-1:0]   rdata;
    logic                   trap_flg;
    logic [`CSR_XLEN-1:0]   trap_vector;
    priv_mode_e             priv_mode;

    vector_t vecs[$];

    csr_unit UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .csr_cmd     (csr_cmd),
        .csr_addr    (csr_addr),
        .op1_data    (op1_data),
        .pc          (pc),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .meip        (meip),
        .msip        (msip),
        .rdata       (rdata),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector),
        .priv_mode   (priv_mode)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    task automatic stop_failed();
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          line_no;
        int          n_fields;
        string       line;
        logic [63:0] f [13];
        vector_t     v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the test vector file %s", VEC_FILE);
            stop_failed();
        end
        line_no = 0;
        while (!$feof(fd)) begin
            if (line_no >= MAX_LINES) begin
                $display("ERROR: %s is longer than %0d lines", VEC_FILE, MAX_LINES);
                stop_failed();
            end
            line_no++;
            if ($fgets(line, fd) == 0) begin
                break;                      // End of file
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;                   // Blank or comment line
            end
            n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                               f[7], f[8], f[9], f[10], f[11], f[12]);
            if (n_fields != 13) begin
                $display("ERROR: line %0d of %s has %0d fields instead of 13",
                         line_no, VEC_FILE, n_fields);
                stop_failed();
            end
            v.valid    = f[0][0];
            v.cmd      = f[1][2:0];
            v.addr     = f[2][11:0];
            v.op1      = f[3][`CSR_XLEN-1:0];
            v.pc       = f[4][`CSR_XLEN-1:0];
            v.meip     = f[5][0];
            v.msip     = f[6][0];
            v.mtime    = f[7];
            v.mtimecmp = f[8];
            v.rdata    = f[9][`CSR_XLEN-1:0];
            v.trap     = f[10][0];
            v.vec      = f[11][`CSR_XLEN-1:0];
            v.mode     = f[12][1:0];
            vecs.push_back(v);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("ERROR: no test vectors found in %s", VEC_FILE);
            stop_failed();
        end
    endtask

    task automatic drive_vector(input vector_t v);
        csr_valid <= v.valid;
        csr_cmd   <= csr_cmd_e'(v.cmd);
        csr_addr  <= v.addr;
        op1_data  <= v.op1;
        pc        <= v.pc;
        meip      <= v.meip;
        msip      <= v.msip;
        mtime     <= v.mtime;
        mtimecmp  <= v.mtimecmp;
    endtask

    initial begin
        int idx;
        rst_n     = 1'b0;
        csr_valid = 1'b0;
        csr_cmd   = CMD_NONE;
        csr_addr  = '0;
        op1_data  = '0;
        pc        = '0;
        mtime     = 64'h100;
        mtimecmp  = '1;                     // Timer far in the future
        meip      = 1'b0;
        msip      = 1'b0;
        load_vectors();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (idx = 0; idx < vecs.size(); idx++) begin
            @(posedge clk);
            drive_vector(vecs[idx]);
            @(negedge clk);                 // Outputs settled mid-cycle
            if (idx > 0) begin
                // Mode update from the previous vector's edge
                check("priv_mode", 64'(priv_mode), 64'(vecs[idx-1].mode));
            end
            check("rdata", 64'(rdata), 64'(vecs[idx].rdata));
            check("trap_flg", 64'(trap_flg), 64'(vecs[idx].trap));
            if (vecs[idx].trap) begin
                check("trap_vector", 64'(trap_vector), 64'(vecs[idx].vec));
            end
        end
        @(posedge clk);
        csr_valid <= 1'b0;
        @(negedge clk);
        check("priv_mode", 64'(priv_mode), 64'(vecs[vecs.size()-1].mode));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
